//--- compile.f
+incdir+.
isaPkg.sv
wbCtrlPkg.sv
destParser.sv
writeBack.sv
memWbLatch.sv
regFile.sv
wbSubsystem.sv
tbClock.sv
wbTb.sv

//--- run.sh
#!/bin/sh
# Build and run the write-back testbench with Verilator.
# Nonzero exit when the build fails, the run fails or the log shows a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module wbTb -f compile.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VwbTb > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
   echo "No pass message found in $LOG"
   exit 1
fi
exit 0

//--- wbTb.sv
/*
  Table-driven testbench for the write-back subsystem.
  Each row goes through one full four-phase handshake and is then read
  back on the combinational port. Random rows use xorshift, seed 31119.
*/
`timescale 1ns/1ns
`include "wisc_macros.svh"

module wbTb;
   import isaPkg::*;

   localparam int FIXED_ROWS = 15;
   localparam int NUM_ROWS   = 23;
   // Reset plus twelve cycles per row, 8 ns each
   localparam int TIMEOUT_NS = (NUM_ROWS * 12 + 4) * 8;
   // Opcode mix for the random rows
   localparam opcode_t MIX [12] = '{LBI, SLBI, LD, STU, JAL, JALR, 5'b11011, 5'b11100,
                                    5'b01000, ST, 5'b01101, NOP};

   logic    clk;
   logic    rst;
   logic    req;
   logic    ack;
   word_t   instr;
   word_t   incrPC;
   word_t   memData;
   word_t   aluData;
   word_t   immData;
   regIdx_t rdIdx;
   word_t   rdData;
   regIdx_t fwdRd;
   logic    fwdRegWrite;
   logic    fwdValid;

   // Stimulus table, one entry per row
   string   nameTab  [NUM_ROWS];
   word_t   instrTab [NUM_ROWS];
   word_t   pcTab    [NUM_ROWS];
   word_t   memTab   [NUM_ROWS];
   word_t   aluTab   [NUM_ROWS];
   word_t   immTab   [NUM_ROWS];
   // Expected results
   regIdx_t destTab  [NUM_ROWS];
   logic    wrTab    [NUM_ROWS];
   word_t   dataTab  [NUM_ROWS];
   int      rowCount;

   // Register file model
   word_t       model [`REG_COUNT];
   logic [31:0] rngState;
   int          errors;
   int          failedTests;
   int          testsRun;

   tbClock iClock (
      .clk (clk),
      .rst (rst)
   );

   wbSubsystem DUT (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .ack         (ack),
      .instr       (instr),
      .incrPC      (incrPC),
      .memData     (memData),
      .aluData     (aluData),
      .immData     (immData),
      .rdIdx       (rdIdx),
      .rdData      (rdData),
      .fwdRd       (fwdRd),
      .fwdRegWrite (fwdRegWrite),
      .fwdValid    (fwdValid)
   );

   //////////////////////////////////////////////////////////////////////
   // Encoding, random source and reference decode
   //////////////////////////////////////////////////////////////////////
   function automatic word_t encode(opcode_t op, regIdx_t rs, regIdx_t rt, regIdx_t rd);
      return {op, rs, rt, rd, 2'b00};
   endfunction

   // xorshift32
   function automatic logic [31:0] nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic regIdx_t modelDest(word_t ins);
      opcode_t op;
      op = ins[15:11];
      if (op == JAL || op == JALR) return regIdx_t'(`LINK_REG);
      if (op == LBI) return ins[10:8];
      // 11xxx register-register group
      if (op[4:3] == 2'b11) return ins[4:2];
      if (op[4:2] == 3'b100 && op != LD) return ins[10:8];
      return ins[7:5];
   endfunction

   function automatic logic modelWrite(word_t ins);
      opcode_t op;
      op = ins[15:11];
      // 0000x, 0001x, J, JR, 011xx and ST leave the file alone
      return !(op[4:2] == 3'b000 || op == J || op == JR || op[4:2] == 3'b011 || op == ST);
   endfunction

   function automatic word_t modelData(word_t ins, word_t pc, word_t mem, word_t alu,
                                       word_t imm);
      opcode_t op;
      op = ins[15:11];
      if (op == LBI || op == SLBI) return imm;
      if (op == LD) return mem;
      if (op[4:1] == 4'b0000 || op == JAL || op == JALR) return pc;
      return alu;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Table construction
   //////////////////////////////////////////////////////////////////////
   task automatic addRow(input string name, input word_t ins, input word_t pc,
                         input word_t mem, input word_t alu, input word_t imm,
                         input regIdx_t dest, input logic wr, input word_t data);
      nameTab[rowCount]  = name;
      instrTab[rowCount] = ins;
      pcTab[rowCount]    = pc;
      memTab[rowCount]   = mem;
      aluTab[rowCount]   = alu;
      immTab[rowCount]   = imm;
      destTab[rowCount]  = dest;
      wrTab[rowCount]    = wr;
      dataTab[rowCount]  = data;
      rowCount++;
   endtask

   task automatic buildTable();
      opcode_t op;
      regIdx_t rs;
      regIdx_t rt;
      regIdx_t rd;
      word_t   ins;
      word_t   pc;
      word_t   mem;
      word_t   alu;
      word_t   imm;
      // Data sources and destination fields
      addRow("lbi_imm", encode(LBI, 3'd1, 3'd2, 3'd3), 16'h0102, 16'h1111, 16'h2222,
             16'h00A5, 3'd1, 1'b1, 16'h00A5);
      addRow("slbi_imm", encode(SLBI, 3'd2, 3'd5, 3'd6), 16'h0104, 16'h1313, 16'h2424,
             16'hA5C3, 3'd2, 1'b1, 16'hA5C3);
      addRow("ld_mem", encode(LD, 3'd1, 3'd4, 3'd0), 16'h0106, 16'hBEEF, 16'h0010,
             16'h0000, 3'd4, 1'b1, 16'hBEEF);
      addRow("stu_rs", encode(STU, 3'd5, 3'd1, 3'd2), 16'h0108, 16'hDEAD, 16'h0400,
             16'h0007, 3'd5, 1'b1, 16'h0400);
      addRow("jal_link", encode(JAL, 3'd0, 3'd3, 3'd1), 16'h0042, 16'h0F0F, 16'h0100,
             16'h0020, 3'd7, 1'b1, 16'h0042);
      addRow("jalr_link", encode(JALR, 3'd2, 3'd0, 3'd5), 16'h0080, 16'h3333, 16'h4444,
             16'h5555, 3'd7, 1'b1, 16'h0080);
      // ADD, SLL and SEQ write Rd
      addRow("add_rd", encode(5'b11011, 3'd1, 3'd2, 3'd6), 16'h010A, 16'h6666, 16'h1234,
             16'h7777, 3'd6, 1'b1, 16'h1234);
      addRow("sll_rd", encode(5'b11010, 3'd3, 3'd4, 3'd0), 16'h010C, 16'h8888, 16'h5678,
             16'h9999, 3'd0, 1'b1, 16'h5678);
      addRow("seq_rd", encode(5'b11100, 3'd6, 3'd7, 3'd1), 16'h010E, 16'hAAAA, 16'h0001,
             16'hBBBB, 3'd1, 1'b1, 16'h0001);
      // ADDI writes Rt
      addRow("addi_rt", encode(5'b01000, 3'd1, 3'd3, 3'd7), 16'h0110, 16'hCCCC, 16'h7FFF,
             16'hDDDD, 3'd3, 1'b1, 16'h7FFF);
      // Non-writing group
      addRow("st_nowrite", encode(ST, 3'd3, 3'd4, 3'd2), 16'h0114, 16'h1357, 16'h2468,
             16'h369C, 3'd3, 1'b0, 16'h0000);
      addRow("beqz_nowrite", encode(5'b01100, 3'd1, 3'd6, 3'd0), 16'h0116, 16'h4321,
             16'h8765, 16'hCBA9, 3'd6, 1'b0, 16'h0000);
      addRow("j_nowrite", encode(J, 3'd2, 3'd1, 3'd3), 16'h0118, 16'h0DD0, 16'h0EE0,
             16'h0FF0, 3'd1, 1'b0, 16'h0000);
      addRow("jr_nowrite", encode(JR, 3'd4, 3'd2, 3'd5), 16'h011A, 16'h1AB1, 16'h2BC2,
             16'h3CD3, 3'd2, 1'b0, 16'h0000);
      addRow("nop_nowrite", encode(NOP, 3'd5, 3'd3, 3'd6), 16'h011C, 16'h4DE4, 16'h5EF5,
             16'h6F06, 3'd3, 1'b0, 16'h0000);

      // Random rows, expected values from the reference decode
      rngState = 32'd31119;
      for (int r = FIXED_ROWS; r < NUM_ROWS; r++) begin
         op  = MIX[int'(nextRandom() % 32'd12)];
         rs  = regIdx_t'(nextRandom());
         rt  = regIdx_t'(nextRandom());
         rd  = regIdx_t'(nextRandom());
         ins = encode(op, rs, rt, rd);
         pc  = word_t'(nextRandom());
         mem = word_t'(nextRandom());
         alu = word_t'(nextRandom());
         imm = word_t'(nextRandom());
         addRow($sformatf("rand_%0d", r - FIXED_ROWS), ins, pc, mem, alu, imm,
                modelDest(ins), modelWrite(ins), modelData(ins, pc, mem, alu, imm));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Compare tasks and reporting
   //////////////////////////////////////////////////////////////////////
   task automatic checkWord(input string test, input string what, input word_t exp,
                            input word_t act);
      if (act !== exp) begin
         $display("FAILED %s: %s expected %h actual %h", test, what, exp, act);
         errors++;
      end
   endtask

   task automatic checkIdx(input string test, input string what, input regIdx_t exp,
                           input regIdx_t act);
      if (act !== exp) begin
         $display("FAILED %s: %s expected %0d actual %0d", test, what, exp, act);
         errors++;
      end
   endtask

   task automatic checkBit(input string test, input string what, input logic exp,
                           input logic act);
      if (act !== exp) begin
         $display("FAILED %s: %s expected %b actual %b", test, what, exp, act);
         errors++;
      end
   endtask

   task automatic reportTest(input string test, input int startErrors);
      testsRun++;
      if (errors == startErrors) begin
         $display("done %s: ok", test);
      end else begin
         $display("done %s: %0d mismatches", test, errors - startErrors);
         failedTests++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Bus actions
   //////////////////////////////////////////////////////////////////////
   // Address driven on the falling edge, data sampled mid low phase
   task automatic readReg(input regIdx_t idx, output word_t value);
      @(negedge clk);
      rdIdx = idx;
      #2;
      value = rdData;
   endtask

   task automatic sweepRegs(input string test);
      word_t value;
      for (int i = 0; i < `REG_COUNT; i++) begin
         readReg(regIdx_t'(i), value);
         checkWord(test, $sformatf("r%0d", i), model[i], value);
      end
   endtask

   // One full four-phase transfer plus readback
   task automatic runRow(input int row);
      string name;
      int    startErrors;
      int    waitCycles;
      int    pulses;
      int    holdCycles;
      logic  seen;
      word_t value;
      name        = nameTab[row];
      startErrors = errors;
      pulses      = 0;
      holdCycles  = row % 3;
      @(negedge clk);
      instr   = instrTab[row];
      incrPC  = pcTab[row];
      memData = memTab[row];
      aluData = aluTab[row];
      immData = immTab[row];
      req     = 1'b1;
      // ack must rise within two cycles
      waitCycles = 0;
      seen       = 1'b0;
      while (!seen && waitCycles < 2) begin
         @(negedge clk);
         waitCycles++;
         if (fwdValid) pulses++;
         seen = ack;
      end
      if (!seen) begin
         $display("%s: ack never rose after req was raised", name);
         errors++;
         req = 1'b0;
      end else begin
         // Forwarding info during the valid cycle
         checkBit(name, "fwdValid", 1'b1, fwdValid);
         checkIdx(name, "fwdRd", destTab[row], fwdRd);
         checkBit(name, "fwdRegWrite", wrTab[row], fwdRegWrite);
         // Producer stalls with req held, no second capture
         for (int h = 0; h < holdCycles; h++) begin
            @(negedge clk);
            checkBit(name, "ack while req held", 1'b1, ack);
            if (fwdValid) pulses++;
         end
         req        = 1'b0;
         waitCycles = 0;
         seen       = 1'b0;
         while (!seen && waitCycles < 3) begin
            @(negedge clk);
            waitCycles++;
            if (fwdValid) pulses++;
            seen = !ack;
         end
         if (!seen) begin
            $display("%s: ack stayed high after req was dropped", name);
            errors++;
         end
         if (pulses != 1) begin
            $display("%s: fwdValid pulsed %0d times in one transfer", name, pulses);
            errors++;
         end
         if (wrTab[row]) begin
            model[destTab[row]] = dataTab[row];
            readReg(destTab[row], value);
            checkWord(name, "written register", dataTab[row], value);
         end else begin
            // Nothing may change anywhere
            sweepRegs(name);
         end
      end
      reportTest(name, startErrors);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////////////////////////
   initial begin
      int startErrors;
      req         = 1'b0;
      instr       = '0;
      incrPC      = '0;
      memData     = '0;
      aluData     = '0;
      immData     = '0;
      rdIdx       = '0;
      errors      = 0;
      failedTests = 0;
      testsRun    = 0;
      rowCount    = 0;
      for (int i = 0; i < `REG_COUNT; i++) begin
         model[i] = '0;
      end
      buildTable();
      wait (rst === 1'b0);

      // State straight out of reset
      startErrors = errors;
      @(negedge clk);
      checkBit("reset_state", "ack", 1'b0, ack);
      checkBit("reset_state", "fwdValid", 1'b0, fwdValid);
      sweepRegs("reset_state");
      reportTest("reset_state", startErrors);

      for (int r = 0; r < NUM_ROWS; r++) begin
         runRow(r);
      end

      // Whole file against the model
      startErrors = errors;
      sweepRegs("final_sweep");
      reportTest("final_sweep", startErrors);

      $display("Summary: %0d tests, %0d failed, %0d mismatches", testsRun, failedTests,
               errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
      $display("TB FAILED");
      $finish;
   end

endmodule

//--- tbClock.sv
/*
  Testbench clock and reset source. 8 ns period, reset high for the
  first four rising edges and released on a falling edge.
*/
`timescale 1ns/1ns

module tbClock #(
   parameter int HALF_PERIOD  = 4,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst
);

   // Free-running clock
   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // Release away from the rising edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

//--- wbSubsystem.sv
/*
  Write-back subsystem top: MEM/WB latch, write-back stage, register file.
  Write becomes visible on the read port two edges after req is sampled.
*/
`timescale 1ns/1ns

module wbSubsystem (
   input  logic            clk,
   input  logic            rst,
   input  logic            req,
   output logic            ack,
   input  isaPkg::word_t   instr,
   input  isaPkg::word_t   incrPC,
   input  isaPkg::word_t   memData,
   input  isaPkg::word_t   aluData,
   input  isaPkg::word_t   immData,
   input  isaPkg::regIdx_t rdIdx,
   output isaPkg::word_t   rdData,
   output isaPkg::regIdx_t fwdRd,
   output logic            fwdRegWrite,
   output logic            fwdValid
);
   import isaPkg::*;

   // Latched packet
   word_t   wbInstr;
   word_t   wbIncrPC;
   word_t   wbMemData;
   word_t   wbAluData;
   word_t   wbImmData;
   logic    wbValid;

   // Register file write port
   logic    wrEn;
   regIdx_t wrIdx;
   word_t   wrData;

   //////////////////////////////////////////////////////////////////////
   // MEM/WB boundary
   //////////////////////////////////////////////////////////////////////
   memWbLatch iLatch (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .ack       (ack),
      .instrIn   (instr),
      .incrPCIn  (incrPC),
      .memDataIn (memData),
      .aluDataIn (aluData),
      .immDataIn (immData),
      .instr     (wbInstr),
      .incrPC    (wbIncrPC),
      .memData   (wbMemData),
      .aluData   (wbAluData),
      .immData   (wbImmData),
      .valid     (wbValid)
   );

   //////////////////////////////////////////////////////////////////////
   // Write-back and register file
   //////////////////////////////////////////////////////////////////////
   writeBack iWb (
      .instr   (wbInstr),
      .incrPC  (wbIncrPC),
      .memData (wbMemData),
      .aluData (wbAluData),
      .immData (wbImmData),
      .valid   (wbValid),
      .wrEn    (wrEn),
      .wrIdx   (wrIdx),
      .wrData  (wrData)
   );

   regFile iRf (
      .clk    (clk),
      .rst    (rst),
      .wrEn   (wrEn),
      .wrIdx  (wrIdx),
      .wrData (wrData),
      .rdIdx  (rdIdx),
      .rdData (rdData)
   );

   // Forwarding info for the hazard unit
   assign fwdRd       = wrIdx;
   assign fwdRegWrite = wrEn;
   assign fwdValid    = wbValid;

endmodule

//--- regFile.sv
/*
  Eight-entry register file, one write port and one combinational read port.
  No write-to-read bypass: a read of the entry being written returns the
  old value until the clock edge.
*/
`timescale 1ns/1ns
`include "wisc_macros.svh"

module regFile (
   input  logic            clk,
   input  logic            rst,
   input  logic            wrEn,
   input  isaPkg::regIdx_t wrIdx,
   input  isaPkg::word_t   wrData,
   input  isaPkg::regIdx_t rdIdx,
   output isaPkg::word_t   rdData
);
   import isaPkg::*;

   // Register storage
   word_t regs [`REG_COUNT];

   //////////////////////////////////////////////////////////////////////
   // Write port
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         // Architectural state starts at zero
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read port
   //////////////////////////////////////////////////////////////////////
   // Stands in for the decode stage read ports
   assign rdData = regs[rdIdx];

endmodule

//--- memWbLatch.sv
/*
  MEM/WB register with a four-phase req/ack receiver.
  Producer must hold data stable while req is high and must not raise
  req again before ack falls. valid pulses for one cycle per capture.
*/
`timescale 1ns/1ns

module memWbLatch (
   input  logic          clk,
   input  logic          rst,
   input  logic          req,
   output logic          ack,
   input  isaPkg::word_t instrIn,
   input  isaPkg::word_t incrPCIn,
   input  isaPkg::word_t memDataIn,
   input  isaPkg::word_t aluDataIn,
   input  isaPkg::word_t immDataIn,
   output isaPkg::word_t instr,
   output isaPkg::word_t incrPC,
   output isaPkg::word_t memData,
   output isaPkg::word_t aluData,
   output isaPkg::word_t immData,
   output logic          valid
);
   import wbCtrlPkg::*;

   hsState_t state;
   hsState_t nextState;
   logic     capture;

   // Only an idle receiver takes a new packet
   assign capture = (state == HS_IDLE) && req;

   //////////////////////////////////////////////////////////////////////
   // Handshake FSM
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      nextState = state;
      case (state)
         HS_IDLE: begin
            if (req) nextState = HS_ACK;
         end
         HS_ACK: begin
            // Producer may already have dropped req
            nextState = req ? HS_WAIT_DROP : HS_IDLE;
         end
         HS_WAIT_DROP: begin
            if (!req) nextState = HS_IDLE;
         end
         default: nextState = HS_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= HS_IDLE;
      end else begin
         state <= nextState;
      end
   end

   // Decoded from state so both come straight off flops
   assign ack   = (state != HS_IDLE);
   assign valid = (state == HS_ACK);

   //////////////////////////////////////////////////////////////////////
   // Packet register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (capture) begin
         instr   <= instrIn;
         incrPC  <= incrPCIn;
         memData <= memDataIn;
         aluData <= aluDataIn;
         immData <= immDataIn;
      end
   end

endmodule

//--- writeBack.sv
/*
  Write-back stage. Combinational: picks write data by opcode and drives
  the register file write port. wrEn is only meaningful while valid is high.
*/
`timescale 1ns/1ns

module writeBack (
   input  isaPkg::word_t   instr,
   input  isaPkg::word_t   incrPC,
   input  isaPkg::word_t   memData,
   input  isaPkg::word_t   aluData,
   input  isaPkg::word_t   immData,
   input  logic            valid,
   output logic            wrEn,
   output isaPkg::regIdx_t wrIdx,
   output isaPkg::word_t   wrData
);
   import isaPkg::*;
   import wbCtrlPkg::*;

   opcode_t opcode;
   wbSrc_t  wbSrc;
   logic    regWrite;

   assign opcode = opcodeOf(instr);

   //////////////////////////////////////////////////////////////////////
   // Data source decode
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      if (opcode == LBI || opcode == SLBI) begin
         // Immediate already formed upstream
         wbSrc = SRC_IMM;
      end else if (opcode == LD) begin
         wbSrc = SRC_MEM;
      end else if (opcode == HALT || opcode == NOP) begin
         wbSrc = SRC_PC;
      end else if (opcode == JAL || opcode == JALR) begin
         // Return address
         wbSrc = SRC_PC;
      end else begin
         wbSrc = SRC_ALU;
      end
   end

   // Four-way data mux
   always_comb begin
      case (wbSrc)
         SRC_PC:  wrData = incrPC;
         SRC_MEM: wrData = memData;
         SRC_IMM: wrData = immData;
         default: wrData = aluData;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Destination and write enable
   //////////////////////////////////////////////////////////////////////
   destParser iParser (
      .instr    (instr),
      .destReg  (wrIdx),
      .regWrite (regWrite)
   );

   // One write per captured packet
   assign wrEn = valid & regWrite;

endmodule

//--- destParser.sv
/*
  Destination register and register-write decode from the opcode alone.
  Purely combinational. Unused opcodes fall to the Rt field and write.
*/
`timescale 1ns/1ns
`include "wisc_macros.svh"

module destParser (
   input  isaPkg::word_t   instr,
   output isaPkg::regIdx_t destReg,
   output logic            regWrite
);
   import isaPkg::*;

   // Destination field select
   localparam logic [1:0] DST_RT   = 2'b00;
   localparam logic [1:0] DST_RS   = 2'b01;
   localparam logic [1:0] DST_RD   = 2'b10;
   localparam logic [1:0] DST_LINK = 2'b11;

   opcode_t    opcode;
   logic [1:0] destSel;

   assign opcode = opcodeOf(instr);

   //////////////////////////////////////////////////////////////////////
   // Destination field
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      if (opcode == JAL || opcode == JALR) begin
         destSel = DST_LINK;
      end else if (opcode[4:3] == 2'b11 && opcode != LBI) begin
         // Register-register ALU group
         destSel = DST_RD;
      end else if (opcode == LBI || opcode == ST || opcode == SLBI || opcode == STU) begin
         destSel = DST_RS;
      end else begin
         destSel = DST_RT;
      end
   end

   always_comb begin
      case (destSel)
         DST_RS:   destReg = rsField(instr);
         DST_RD:   destReg = rdField(instr);
         DST_LINK: destReg = regIdx_t'(`LINK_REG);
         default:  destReg = rtField(instr);
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Register-write flag
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      regWrite = 1'b1;
      // HALT, NOP and the 0001x group
      if (opcode[4:2] == 3'b000) begin
         regWrite = 1'b0;
      end
      if (opcode == J || opcode == JR) begin
         regWrite = 1'b0;
      end
      // Branches
      if (opcode[4:2] == 3'b011) begin
         regWrite = 1'b0;
      end
      // Plain store, STU writes back its address
      if (opcode == ST) begin
         regWrite = 1'b0;
      end
   end

endmodule

//--- wbCtrlPkg.sv
/*
  Write-back control types: data source select and the receiver FSM states.
  The source encoding matches the four-input data mux in writeBack.
*/

package wbCtrlPkg;

   //////////////////////////////////////////////////////////////////////
   // Write data source select
   //////////////////////////////////////////////////////////////////////
   typedef logic [1:0] wbSrc_t;

   // Incremented PC, for JAL/JALR and the 0000x group
   localparam wbSrc_t SRC_PC  = 2'b00;
   // Load data from memory
   localparam wbSrc_t SRC_MEM = 2'b01;
   // ALU result, default for everything else
   localparam wbSrc_t SRC_ALU = 2'b10;
   // Immediate path for LBI and SLBI
   localparam wbSrc_t SRC_IMM = 2'b11;

   //////////////////////////////////////////////////////////////////////
   // Four-phase receiver states
   //////////////////////////////////////////////////////////////////////
   // HS_IDLE       waiting for req, ack low
   // HS_ACK        packet just captured, ack high, valid pulse
   // HS_WAIT_DROP  ack held until the producer drops req
   typedef enum logic [1:0] {
      HS_IDLE,
      HS_ACK,
      HS_WAIT_DROP
   } hsState_t;

endpackage

//--- isaPkg.sv
/*
  WISC instruction encoding: word, register index and opcode types.
  Opcode lives in bits 15:11, register fields at 10:8, 7:5 and 4:2.
*/
`include "wisc_macros.svh"

package isaPkg;

   // Basic datapath types
   typedef logic [`WORD_WIDTH-1:0]    word_t;
   typedef logic [`REG_IDX_WIDTH-1:0] regIdx_t;
   typedef logic [4:0]                opcode_t;

   //////////////////////////////////////////////////////////////////////
   // Opcodes used by the write-back decode
   //////////////////////////////////////////////////////////////////////
   localparam opcode_t HALT = 5'b00000;
   localparam opcode_t NOP  = 5'b00001;
   localparam opcode_t J    = 5'b00100;
   localparam opcode_t JR   = 5'b00101;
   localparam opcode_t JAL  = 5'b00110;
   localparam opcode_t JALR = 5'b00111;
   localparam opcode_t ST   = 5'b10000;
   localparam opcode_t LD   = 5'b10001;
   localparam opcode_t SLBI = 5'b10010;
   localparam opcode_t STU  = 5'b10011;
   localparam opcode_t LBI  = 5'b11000;

   // Field extraction
   function automatic opcode_t opcodeOf(word_t w);
      return w[15:11];
   endfunction

   // Rs, bits 10:8
   function automatic regIdx_t rsField(word_t w);
      return w[10:8];
   endfunction

   // Rt, bits 7:5
   function automatic regIdx_t rtField(word_t w);
      return w[7:5];
   endfunction

   // Rd, bits 4:2
   function automatic regIdx_t rdField(word_t w);
      return w[4:2];
   endfunction

endpackage

//--- wisc_macros.svh
/*
  Fixed widths and register constants of the WISC datapath.
  These follow the ISA and are not meant to be overridden per instance.
*/
`ifndef WISC_MACROS_SVH
`define WISC_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Data and instruction word
`define WORD_WIDTH 16

// Register file geometry
`define REG_COUNT 8
`define REG_IDX_WIDTH 3

//////////////////////////////////////////////////////////////////////
// Special registers
//////////////////////////////////////////////////////////////////////

// JAL and JALR store the return address here
`define LINK_REG 7

`endif
